// File: pad_pkg.sv
//////////////////////////////////////////////////////////////////////
// Pad ring types: pad variants, per-pad attributes and the default
// variant tables for the muxed and dedicated pads
//////////////////////////////////////////////////////////////////////

package pad_pkg;

  // Default pad counts
  parameter int NMioPadsDefault = 8;
  parameter int NDioPadsDefault = 4;

  // Codes match the pad library variant selection
  typedef enum logic [1:0] {
    pad_bidir      = 2'd0,
    pad_input_only = 2'd1,
    pad_tolerant   = 2'd2,
    pad_open_drain = 2'd3
  } pad_variant_e;

  // Invert sits in bit 0, virtual open drain in bit 1
  typedef struct packed {
    logic virt_od; // Push-pull pad emulates open drain
    logic invert;  // Flip level in both directions
  } pad_attr_t;

  //////////////////////////////////////////////////////////////////////
  // Default variant tables

  // Upper two MIOs serve open-drain buses
  parameter pad_variant_e [NMioPadsDefault-1:0] DefaultMioVariant = '{
    7:       pad_open_drain,
    6:       pad_open_drain,
    default: pad_bidir
  };

  // Clock and mode pads of the debug port only ever receive
  parameter pad_variant_e [NDioPadsDefault-1:0] DefaultDioVariant = '{
    3:       pad_input_only, // TMS
    2:       pad_input_only, // TCK
    default: pad_bidir
  };

endpackage : pad_pkg

// File: jtag_pkg.sv
//////////////////////////////////////////////////////////////////////
// JTAG overlay types: request and response bundles, default pin
// indices and the overlay control state
//////////////////////////////////////////////////////////////////////

package jtag_pkg;

  typedef struct packed {
    logic tck;
    logic tms;
    logic trst_n;
    logic tdi;
  } jtag_req_t;

  typedef struct packed {
    logic tdo;
  } jtag_rsp_t;

  // Levels seen by the TAP while the overlay is off
  parameter jtag_req_t JtagReqIdle = '{tck: 1'b0, tms: 1'b1, trst_n: 1'b0, tdi: 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Pin indices into the combined vector, DIOs above the MIOs

  parameter int StrapIdx = 4;                               // MIO 4
  parameter int TrstIdx  = 2;                               // MIO 2
  parameter int TckIdx   = pad_pkg::NMioPadsDefault + 2;    // DIO 2
  parameter int TmsIdx   = pad_pkg::NMioPadsDefault + 3;    // DIO 3
  parameter int TdiIdx   = pad_pkg::NMioPadsDefault + 0;    // DIO 0
  parameter int TdoIdx   = pad_pkg::NMioPadsDefault + 1;    // DIO 1

  typedef enum logic {
    ovl_func = 1'b0,
    ovl_jtag = 1'b1
  } overlay_state_e;

endpackage : jtag_pkg

// File: pad_ring.sv
//////////////////////////////////////////////////////////////////////
// Pad ring: converts logical values to pad levels and back, applying
// the fixed pad variant and the per-pad attributes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_ring #(
  parameter int NPads = 12,
  parameter pad_pkg::pad_variant_e [NPads-1:0] PadVariant = '{default: pad_pkg::pad_bidir}
) (
  // Logical side
  input  logic [NPads-1:0]                ring_out_i,
  input  logic [NPads-1:0]                ring_oe_i,
  output logic [NPads-1:0]                ring_in_o,
  input  pad_pkg::pad_attr_t [NPads-1:0]  attr_i,
  // Pad side
  input  logic [NPads-1:0]                pad_in_i,
  output logic [NPads-1:0]                pad_out_o,
  output logic [NPads-1:0]                pad_oe_o
);

  for (genvar i = 0; i < NPads; i++) begin : g_pad
    logic out_inv;  // Output level after inversion
    logic is_input;
    logic is_od;

    assign out_inv  = ring_out_i[i] ^ attr_i[i].invert;
    assign is_input = (PadVariant[i] == pad_pkg::pad_input_only);

    // Real open-drain cell or push-pull pad told to behave like one
    assign is_od = (PadVariant[i] == pad_pkg::pad_open_drain) || attr_i[i].virt_od;

    //////////////////////////////////////////////////////////////////////
    // Output path

    // Open drain only ever pulls low, releasing the pad for a 1
    assign pad_out_o[i] = is_od ? 1'b0 : out_inv;

    always_comb begin
      if (is_input) begin
        pad_oe_o[i] = 1'b0;                    // Receiver only
      end else if (is_od) begin
        pad_oe_o[i] = ring_oe_i[i] & ~out_inv;
      end else begin
        pad_oe_o[i] = ring_oe_i[i];            // Bidir and tolerant
      end
    end

    //////////////////////////////////////////////////////////////////////
    // Input path

    assign ring_in_o[i] = pad_in_i[i] ^ attr_i[i].invert;
  end

endmodule : pad_ring

// File: jtag_strap_ctrl.sv
//////////////////////////////////////////////////////////////////////
// JTAG strap control: synchronizes the strap pad and holds the
// overlay state that selects JTAG on the shared pins
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jtag_strap_ctrl (
  input  logic clk_i,
  input  logic rst_i,
  input  logic strap_i,       // Raw strap, asynchronous
  output logic jtag_active_o
);

  typedef logic [1:0] sync_stages_t;

  sync_stages_t             sync_q;
  logic                     strap_sync;
  jtag_pkg::overlay_state_e state_q, state_d;

  // Two-flop synchronizer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], strap_i};
    end
  end

  assign strap_sync = sync_q[1];

  //////////////////////////////////////////////////////////////////////
  // Overlay FSM

  always_comb begin
    state_d = state_q;
    case (state_q)
      jtag_pkg::ovl_func: if (strap_sync)  state_d = jtag_pkg::ovl_jtag;
      jtag_pkg::ovl_jtag: if (!strap_sync) state_d = jtag_pkg::ovl_func;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= jtag_pkg::ovl_func;  // Functional mode out of reset
    end else begin
      state_q <= state_d;
    end
  end

  assign jtag_active_o = (state_q == jtag_pkg::ovl_jtag);

  // Overlay moves only when the synchronized strap disagreed last cycle
  a_active_follows_strap: assert property (@(posedge clk_i) disable iff (rst_i)
    $changed(jtag_active_o) |-> $past(strap_sync != jtag_active_o));

endmodule : jtag_strap_ctrl

// File: jtag_overlay_mux.sv
//////////////////////////////////////////////////////////////////////
// JTAG overlay mux: hands the debug pins to the TAP while JTAG is
// selected and ties off the core's view of them
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module jtag_overlay_mux #(
  parameter int NumIos  = 12,
  parameter int TckIdx  = 10,
  parameter int TmsIdx  = 11,
  parameter int TrstIdx = 2,
  parameter int TdiIdx  = 8,
  parameter int TdoIdx  = 9
) (
  input  logic               jtag_active_i,
  // Core side
  input  logic [NumIos-1:0]  core_out_i,
  input  logic [NumIos-1:0]  core_oe_i,
  output logic [NumIos-1:0]  core_in_o,
  // Pad ring side
  output logic [NumIos-1:0]  ring_out_o,
  output logic [NumIos-1:0]  ring_oe_o,
  input  logic [NumIos-1:0]  ring_in_i,
  // TAP side
  output jtag_pkg::jtag_req_t jtag_req_o,
  input  jtag_pkg::jtag_rsp_t jtag_rsp_i
);

  localparam logic [NumIos-1:0] OneHot = {{(NumIos-1){1'b0}}, 1'b1};

  // Pins the TAP samples
  localparam logic [NumIos-1:0] JtagInPins =
    (OneHot << TckIdx) | (OneHot << TmsIdx) | (OneHot << TrstIdx) | (OneHot << TdiIdx);
  localparam logic [NumIos-1:0] JtagPins = JtagInPins | (OneHot << TdoIdx);

  // TMS idles high, everything else reads 0 to the core
  localparam logic [NumIos-1:0] TieOffValues = OneHot << TmsIdx;

  always_comb begin
    // Straight pass-through by default
    ring_out_o = core_out_i;
    ring_oe_o  = core_oe_i;
    core_in_o  = ring_in_i;
    jtag_req_o = jtag_pkg::JtagReqIdle;

    if (jtag_active_i) begin
      jtag_req_o.tck    = ring_in_i[TckIdx];
      jtag_req_o.tms    = ring_in_i[TmsIdx];
      jtag_req_o.trst_n = ring_in_i[TrstIdx];
      jtag_req_o.tdi    = ring_in_i[TdiIdx];

      // Core drive on the debug inputs is dropped
      ring_out_o = core_out_i & ~JtagInPins;
      ring_oe_o  = core_oe_i & ~JtagInPins;

      ring_out_o[TdoIdx] = jtag_rsp_i.tdo;
      ring_oe_o[TdoIdx]  = 1'b1;

      core_in_o = (ring_in_i & ~JtagPins) | TieOffValues;
    end
  end

  // No contention on pins the external debugger drives
  a_in_pins_released: assert final (!jtag_active_i || ((ring_oe_o & JtagInPins) == '0))
    else $error("output enable on JTAG input pin while overlay active");

endmodule : jtag_overlay_mux

// File: chip_io_top.sv
//////////////////////////////////////////////////////////////////////
// Chip I/O top: strap control, JTAG overlay mux and pad ring
// between the MIO/DIO pads and the core
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module chip_io_top #(
  parameter int NMioPads = pad_pkg::NMioPadsDefault,
  parameter int NDioPads = pad_pkg::NDioPadsDefault,
  parameter pad_pkg::pad_variant_e [NMioPads-1:0] MioVariant = pad_pkg::DefaultMioVariant,
  parameter pad_pkg::pad_variant_e [NDioPads-1:0] DioVariant = pad_pkg::DefaultDioVariant,
  // Overlay pins, indices into {dio, mio}
  parameter int StrapIdx = jtag_pkg::StrapIdx,
  parameter int TckIdx   = jtag_pkg::TckIdx,
  parameter int TmsIdx   = jtag_pkg::TmsIdx,
  parameter int TrstIdx  = jtag_pkg::TrstIdx,
  parameter int TdiIdx   = jtag_pkg::TdiIdx,
  parameter int TdoIdx   = jtag_pkg::TdoIdx
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // Pads
  input  logic [NMioPads-1:0]               mio_pad_in_i,
  output logic [NMioPads-1:0]               mio_pad_out_o,
  output logic [NMioPads-1:0]               mio_pad_oe_o,
  input  logic [NDioPads-1:0]               dio_pad_in_i,
  output logic [NDioPads-1:0]               dio_pad_out_o,
  output logic [NDioPads-1:0]               dio_pad_oe_o,
  input  pad_pkg::pad_attr_t [NMioPads-1:0] mio_attr_i,
  input  pad_pkg::pad_attr_t [NDioPads-1:0] dio_attr_i,
  // Core
  input  logic [NMioPads+NDioPads-1:0]      core_out_i,
  input  logic [NMioPads+NDioPads-1:0]      core_oe_i,
  output logic [NMioPads+NDioPads-1:0]      core_in_o,
  output jtag_pkg::jtag_req_t               jtag_req_o,
  input  jtag_pkg::jtag_rsp_t               jtag_rsp_i,
  output logic                              jtag_active_o
);

  localparam int NumIos = NMioPads + NDioPads;

  typedef logic [NumIos-1:0] io_vec_t;

  io_vec_t ring_out, ring_oe, ring_in;
  io_vec_t pad_in, pad_out, pad_oe;
  logic    jtag_active;

  // DIOs sit above the MIOs
  assign pad_in = {dio_pad_in_i, mio_pad_in_i};
  assign {dio_pad_out_o, mio_pad_out_o} = pad_out;
  assign {dio_pad_oe_o, mio_pad_oe_o}   = pad_oe;

  jtag_strap_ctrl u_jtag_strap_ctrl (
    .clk_i         ( clk_i            ),
    .rst_i         ( rst_i            ),
    .strap_i       ( pad_in[StrapIdx] ), // Raw level, ahead of inversion
    .jtag_active_o ( jtag_active      )
  );

  assign jtag_active_o = jtag_active;

  jtag_overlay_mux #(
    .NumIos  ( NumIos  ),
    .TckIdx  ( TckIdx  ),
    .TmsIdx  ( TmsIdx  ),
    .TrstIdx ( TrstIdx ),
    .TdiIdx  ( TdiIdx  ),
    .TdoIdx  ( TdoIdx  )
  ) u_jtag_overlay_mux (
    .jtag_active_i ( jtag_active ),
    .core_out_i    ( core_out_i  ),
    .core_oe_i     ( core_oe_i   ),
    .core_in_o     ( core_in_o   ),
    .ring_out_o    ( ring_out    ),
    .ring_oe_o     ( ring_oe     ),
    .ring_in_i     ( ring_in     ),
    .jtag_req_o    ( jtag_req_o  ),
    .jtag_rsp_i    ( jtag_rsp_i  )
  );

  pad_ring #(
    .NPads      ( NumIos                   ),
    .PadVariant ( {DioVariant, MioVariant} )
  ) u_pad_ring (
    .ring_out_i ( ring_out                 ),
    .ring_oe_i  ( ring_oe                  ),
    .ring_in_o  ( ring_in                  ),
    .attr_i     ( {dio_attr_i, mio_attr_i} ),
    .pad_in_i   ( pad_in                   ),
    .pad_out_o  ( pad_out                  ),
    .pad_oe_o   ( pad_oe                   )
  );

endmodule : chip_io_top

// File: tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset generator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter realtime Period      = 4ns,
  parameter int      ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Release just after an edge, like the other stimulus
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    #1ns rst_o = 1'b0;
  end

endmodule : tb_clk_gen

// File: tb_chip_io.sv
//////////////////////////////////////////////////////////////////////
// Chip I/O testbench: random pad and core stimulus, strap sequences
// and a reference model of the pad ring and the JTAG overlay
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_chip_io;

  localparam int NMio   = pad_pkg::NMioPadsDefault;
  localparam int NDio   = pad_pkg::NDioPadsDefault;
  localparam int NumIos = NMio + NDio;

  localparam int ResetLen = 12;
  localparam int PassLen  = 64;
  localparam int OdLen    = 64;
  localparam int TieLen   = 64;
  localparam int MaxHold  = 31;
  localparam int Limit    = ResetLen + PassLen + OdLen + TieLen + 2 * MaxHold + 50;

  localparam pad_pkg::pad_variant_e [NumIos-1:0] Variant =
    {pad_pkg::DefaultDioVariant, pad_pkg::DefaultMioVariant};

  typedef logic [NumIos-1:0] io_vec_t;

  logic                          clk, rst;
  logic [NMio-1:0]               mio_pad_in, mio_pad_out, mio_pad_oe;
  logic [NDio-1:0]               dio_pad_in, dio_pad_out, dio_pad_oe;
  pad_pkg::pad_attr_t [NMio-1:0] mio_attr;
  pad_pkg::pad_attr_t [NDio-1:0] dio_attr;
  io_vec_t                       core_out, core_oe, core_in;
  jtag_pkg::jtag_req_t           jtag_req;
  jtag_pkg::jtag_rsp_t           jtag_rsp;
  logic                          jtag_active;

  logic [15:0] lfsr_q;
  logic        model_sync1, model_sync2, model_active;  // Strap delay model
  int          cycle_cnt, check_cnt, test_errors, total_errors, failed_tests;
  string       cur_test;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

  chip_io_top #(
    .NMioPads ( NMio ),
    .NDioPads ( NDio )
  ) DUT (
    .clk_i         ( clk         ),
    .rst_i         ( rst         ),
    .mio_pad_in_i  ( mio_pad_in  ),
    .mio_pad_out_o ( mio_pad_out ),
    .mio_pad_oe_o  ( mio_pad_oe  ),
    .dio_pad_in_i  ( dio_pad_in  ),
    .dio_pad_out_o ( dio_pad_out ),
    .dio_pad_oe_o  ( dio_pad_oe  ),
    .mio_attr_i    ( mio_attr    ),
    .dio_attr_i    ( dio_attr    ),
    .core_out_i    ( core_out    ),
    .core_oe_i     ( core_oe     ),
    .core_in_o     ( core_in     ),
    .jtag_req_o    ( jtag_req    ),
    .jtag_rsp_i    ( jtag_rsp    ),
    .jtag_active_o ( jtag_active )
  );

  //////////////////////////////////////////////////////////////////////
  // Random numbers

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val[i] = lfsr_q[0];
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic compare_vec(input string name, input io_vec_t got, input io_vec_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_req(input string name, input jtag_pkg::jtag_req_t got,
                             input jtag_pkg::jtag_req_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
      test_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model

  task automatic step_model();
    io_vec_t pads;
    pads = {dio_pad_in, mio_pad_in};
    if (rst) begin
      model_sync1  = 1'b0;
      model_sync2  = 1'b0;
      model_active = 1'b0;
    end else begin
      model_active = model_sync2;
      model_sync2  = model_sync1;
      model_sync1  = pads[jtag_pkg::StrapIdx];
    end
  endtask

  task automatic check_outputs();
    pad_pkg::pad_attr_t [NumIos-1:0] attr;
    io_vec_t inv, ring_in, ring_out, ring_oe, exp_cin, exp_out, exp_oe, got_out, got_oe;
    jtag_pkg::jtag_req_t exp_req;
    logic od, lvl;
    attr     = {dio_attr, mio_attr};
    for (int i = 0; i < NumIos; i++) inv[i] = attr[i].invert;
    ring_in  = {dio_pad_in, mio_pad_in} ^ inv;
    ring_out = core_out;
    ring_oe  = core_oe;
    exp_cin  = ring_in;
    exp_req  = '{tck: 1'b0, tms: 1'b1, trst_n: 1'b0, tdi: 1'b0};
    if (model_active) begin
      exp_req = '{tck: ring_in[jtag_pkg::TckIdx], tms: ring_in[jtag_pkg::TmsIdx],
                  trst_n: ring_in[jtag_pkg::TrstIdx], tdi: ring_in[jtag_pkg::TdiIdx]};
      foreach (exp_cin[i]) begin
        if (i inside {jtag_pkg::TckIdx, jtag_pkg::TmsIdx, jtag_pkg::TrstIdx,
                      jtag_pkg::TdiIdx}) begin
          ring_out[i] = 1'b0;  // Core drive masked
          ring_oe[i]  = 1'b0;
          exp_cin[i]  = (i == jtag_pkg::TmsIdx);
        end
      end
      ring_out[jtag_pkg::TdoIdx] = jtag_rsp.tdo;
      ring_oe[jtag_pkg::TdoIdx]  = 1'b1;
      exp_cin[jtag_pkg::TdoIdx]  = 1'b0;
    end
    got_out = {dio_pad_out, mio_pad_out};
    got_oe  = {dio_pad_oe, mio_pad_oe};
    for (int i = 0; i < NumIos; i++) begin
      od  = (Variant[i] == pad_pkg::pad_open_drain) || attr[i].virt_od;
      lvl = ring_out[i] ^ inv[i];
      exp_out[i] = od ? 1'b0 : lvl;
      if (Variant[i] == pad_pkg::pad_input_only) exp_oe[i] = 1'b0;
      else exp_oe[i] = od ? (ring_oe[i] & ~lvl) : ring_oe[i];
      if (od && got_out[i] && got_oe[i]) begin
        $display("t=%0t open-drain pad %0d drives a high level", $time, i);
        test_errors++;
      end
    end
    compare_vec("core_in_o", core_in, exp_cin);
    compare_vec("pad_out", got_out, exp_out);
    compare_vec("pad_oe", got_oe, exp_oe);
    compare_req("jtag_req_o", jtag_req, exp_req);
    compare_bit("jtag_active_o", jtag_active, model_active);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic run_cycle(input logic strap, input logic all_oe);
    logic [31:0] r;
    @(posedge clk);
    step_model();
    #1;
    rand_bits(NMio, r);
    mio_pad_in = r[NMio-1:0];
    mio_pad_in[jtag_pkg::StrapIdx] = strap;
    rand_bits(NDio, r);
    dio_pad_in = r[NDio-1:0];
    rand_bits(NumIos, r);
    core_out = r[NumIos-1:0];
    rand_bits(NumIos, r);
    core_oe = all_oe ? '1 : r[NumIos-1:0];  // All enables on exercise open drain
    rand_bits(2 * NMio, r);
    mio_attr = r[2*NMio-1:0];
    rand_bits(2 * NDio, r);
    dio_attr = r[2*NDio-1:0];
    rand_bits(1, r);
    jtag_rsp.tdo = r[0];
    #1;
    check_outputs();
  endtask

  // Holds the strap and measures edges until the overlay follows it
  task automatic hold_strap(input logic strap, input int len);
    int lat;
    lat = -1;
    for (int n = 0; n < len; n++) begin
      run_cycle(strap, 1'b0);
      if (lat < 0 && jtag_active === strap) lat = n;
    end
    if (lat != 3) begin
      $display("t=%0t jtag_active_o followed the strap after %0d edges, not 3", $time, lat);
      test_errors++;
    end
  endtask

  task automatic stretch_len(output int len);
    logic [31:0] r;
    rand_bits(5, r);
    len = 8 + (r % 24);  // 8 to 31 cycles
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %-13s %s, %0d errors", cur_test, (test_errors == 0) ? "ok" : "FAIL",
             test_errors);
    total_errors += test_errors;
    if (test_errors != 0) failed_tests++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    int len;
    mio_pad_in   = '0;
    dio_pad_in   = '0;
    mio_attr     = '0;
    dio_attr     = '0;
    core_out     = '0;
    core_oe      = '0;
    jtag_rsp     = '0;
    lfsr_q       = 16'd54;
    check_cnt    = 0;
    total_errors = 0;
    failed_tests = 0;

    begin_test("reset");
    repeat (ResetLen) run_cycle(1'b0, 1'b0);
    end_test();

    begin_test("pass_through");
    repeat (PassLen) run_cycle(1'b0, 1'b0);
    end_test();

    begin_test("open_drain");
    repeat (OdLen) run_cycle(1'b0, 1'b1);
    end_test();

    begin_test("activation");
    stretch_len(len);
    hold_strap(1'b1, len);
    end_test();

    begin_test("tie_offs");
    repeat (TieLen) run_cycle(1'b1, 1'b0);
    end_test();

    begin_test("deactivation");
    stretch_len(len);
    hold_strap(1'b0, len);
    end_test();

    $display("summary: 6 tests run, %0d with errors, %0d checks, %0d errors",
             failed_tests, check_cnt, total_errors);
    if (total_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < Limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", Limit);
    $display("tests failed");
    $finish;
  end

endmodule : tb_chip_io

// File: chip_io_top.f
pad_pkg.sv
jtag_pkg.sv
pad_ring.sv
jtag_strap_ctrl.sv
jtag_overlay_mux.sv
chip_io_top.sv
tb_clk_gen.sv
tb_chip_io.sv

// File: Bender.yml
package:
  name: chip_io

sources:
  - pad_pkg.sv
  - jtag_pkg.sv
  - pad_ring.sv
  - jtag_strap_ctrl.sv
  - jtag_overlay_mux.sv
  - chip_io_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_chip_io.sv
